/* Makefile */
# Verilator build and run for the serial multiplexer testbench

VERILATOR ?= verilator
TOP       ?= dzMuxTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= sources.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hw/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

check:
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no passing result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/dzCharTimer.sv */
//////////////////////////////
// Character timer, paces one transmit per character time
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dzMux_defines.svh"

module dzCharTimer (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clr,
   input  logic                         load,
   input  logic [$clog2(`DZ_LINES)-1:0] lineIn,
   input  logic [7:0]                   charIn,
   output logic                         busy,
   output logic                         txValid,
   output logic [$clog2(`DZ_LINES)-1:0] txLine,
   output logic [7:0]                   txChar
);

   localparam int CntW = $clog2(`DZ_CHAR_CYCLES);

   logic [CntW-1:0] count;

   // Character held for the whole character time
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         txLine <= lineIn;
         txChar <= charIn;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy    <= 1'b0;
         txValid <= 1'b0;
         count   <= '0;
      end
      else if (clr)
      begin
         // Pending character is abandoned
         busy    <= 1'b0;
         txValid <= 1'b0;
         count   <= '0;
      end
      else
      begin
         txValid <= 1'b0;
         if (load)
         begin
            busy  <= 1'b1;
            count <= CntW'(`DZ_CHAR_CYCLES - 1);
         end
         // Busy stays up through the pulse cycle
         else if (txValid)
            busy <= 1'b0;
         else if (busy)
         begin
            if (count == '0)
               txValid <= 1'b1;
            else
               count <= count - 1'b1;
         end
      end
   end

   // Register block filters TDR writes while busy
   assert property (@(posedge clk) disable iff (rst) load |-> !busy)
      else $error("timer loaded while busy");

endmodule

`default_nettype wire

/* hw/dzIntr.sv */
//////////////////////////////
// Receive and transmit interrupt machines
// Arbiter commits to a vector at acknowledge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzIntr
   import dzPkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic clr,
   input  logic iack,
   input  logic vectRead,
   input  logic rie,
   input  logic rrdy,
   input  logic rbufRead,
   input  logic tie,
   input  logic trdy,
   input  logic tdrWrite,
   output logic rxIntr,
   output logic txIntr,
   output logic rxVector
);

   logic [2:0] rxState;
   logic [2:0] txState;
   logic [2:0] arbState;
   logic       rxClr;
   logic       txClr;

   // Common request sequence, set then served then done by the CPU
   function automatic logic [2:0] reqNext(input logic [2:0] state,
                                          input logic       set,
                                          input logic       served,
                                          input logic       done);
      reqNext = state;
      case (state)
         stIdle:
            if (set)
               reqNext = stAct;
         stAct:
            if (served)
               reqNext = stWait;
         stWait:
            if (done)
               reqNext = stDone;
         stDone:
            if (!done)
               reqNext = stIdle;
         default:
            reqNext = stIdle;
      endcase
   endfunction

   //////////////////////////////
   // Request machines
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxState <= stIdle;
         txState <= stIdle;
      end
      else if (clr)
      begin
         rxState <= stIdle;
         txState <= stIdle;
      end
      else
      begin
         // RBUF read retires a receive request
         rxState <= reqNext(rxState, rrdy & rie, rxClr, rbufRead);
         // TDR write retires a transmit request
         txState <= reqNext(txState, trdy & tie, txClr, tdrWrite);
      end
   end

   // Enable masks the output only, state is kept
   assign rxIntr = (rxState == stAct) & rie;
   assign txIntr = (txState == stAct) & tie;

   //////////////////////////////
   // Arbiter
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         arbState <= arbIdle;
         rxVector <= 1'b0;
      end
      else if (clr)
      begin
         arbState <= arbIdle;
         rxVector <= 1'b0;
      end
      else
      begin
         case (arbState)
            arbIdle:
               if ((rxState == stAct) || (txState == stAct))
                  arbState <= arbIack;
            arbIack:
               if (iack)
               begin
                  // Receive wins if it is up by now
                  rxVector <= rxIntr;
                  arbState <= arbVectRead;
               end
            arbVectRead:
               if (vectRead)
                  arbState <= arbVectClr;
            arbVectClr:
               if (!vectRead)
                  arbState <= rxVector ? arbRxDone : arbTxDone;
            arbRxDone,
            arbTxDone:
               arbState <= arbIdle;
            default:
               arbState <= arbIdle;
         endcase
      end
   end

   // One-cycle clear of the machine that was served
   assign rxClr = (arbState == arbRxDone);
   assign txClr = (arbState == arbTxDone);

   // RBUF read and TDR write are separate bus cycles
   assert property (@(posedge clk) disable iff (rst)
                    !((rxState == stDone) && (txState == stDone)))
      else $error("both interrupt machines done together");

endmodule

`default_nettype wire

/* hw/dzMux.sv */
//////////////////////////////
// Serial line multiplexer top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dzMux_defines.svh"

module dzMux
   import dzPkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   // APB
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [3:0]                   paddr,
   input  logic [15:0]                  pwdata,
   output logic [15:0]                  prdata,
   output logic                         pready,
   output logic                         pslverr,
   // Assembled receive characters
   input  logic                         rxValid,
   input  logic [$clog2(`DZ_LINES)-1:0] rxLine,
   input  logic [7:0]                   rxChar,
   // Whole transmit characters
   output logic                         txValid,
   output logic [$clog2(`DZ_LINES)-1:0] txLine,
   output logic [7:0]                   txChar,
   // Interrupt handshake
   input  logic                         iack,
   input  logic                         vectRead,
   output logic                         rxIntr,
   output logic                         txIntr,
   output logic                         rxVector
);

   dzRbuf_t    head;
   logic       notEmpty;
   logic       pop;
   logic       busy;
   logic       load;
   logic [1:0] txLineIn;
   logic [7:0] txCharIn;
   logic       clrPulse;
   logic       rie;
   logic       tie;
   logic       mse;
   logic       rrdy;
   logic       trdy;
   logic       rbufRead;
   logic       tdrWrite;
   logic       rxPush;

   // Characters are taken only while the scanner is on
   assign rxPush = rxValid & mse;

   dzRegs i_regs (
      .clk      (clk),
      .rst      (rst),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .head     (head),
      .notEmpty (notEmpty),
      .pop      (pop),
      .busy     (busy),
      .load     (load),
      .txLineIn (txLineIn),
      .txCharIn (txCharIn),
      .clrPulse (clrPulse),
      .rie      (rie),
      .tie      (tie),
      .mse      (mse),
      .rrdy     (rrdy),
      .trdy     (trdy),
      .rbufRead (rbufRead),
      .tdrWrite (tdrWrite)
   );

   dzRxSilo i_silo (
      .clk      (clk),
      .rst      (rst),
      .clr      (clrPulse),
      .push     (rxPush),
      .line     (rxLine),
      .char     (rxChar),
      .pop      (pop),
      .head     (head),
      .notEmpty (notEmpty)
   );

   dzCharTimer i_timer (
      .clk      (clk),
      .rst      (rst),
      .clr      (clrPulse),
      .load     (load),
      .lineIn   (txLineIn),
      .charIn   (txCharIn),
      .busy     (busy),
      .txValid  (txValid),
      .txLine   (txLine),
      .txChar   (txChar)
   );

   dzIntr i_intr (
      .clk      (clk),
      .rst      (rst),
      .clr      (clrPulse),
      .iack     (iack),
      .vectRead (vectRead),
      .rie      (rie),
      .rrdy     (rrdy),
      .rbufRead (rbufRead),
      .tie      (tie),
      .trdy     (trdy),
      .tdrWrite (tdrWrite),
      .rxIntr   (rxIntr),
      .txIntr   (txIntr),
      .rxVector (rxVector)
   );

endmodule

`default_nettype wire

/* hw/dzMux_defines.svh */
//////////////////////////////
// Serial multiplexer sizes and APB register map
//////////////////////////////

`ifndef DZMUX_DEFINES_SVH
`define DZMUX_DEFINES_SVH

// Receive silo entries
`define DZ_SILO_DEPTH 8
// Clock cycles in one character time
`define DZ_CHAR_CYCLES 12
// Serial lines served by the mux
`define DZ_LINES 4

// Register byte addresses
`define DZ_ADDR_CSR 0
`define DZ_ADDR_RBUF 4
`define DZ_ADDR_TDR 8

`endif

/* hw/dzPkg.sv */
//////////////////////////////
// Register layouts shared by the multiplexer blocks
//////////////////////////////

`default_nettype none

package dzPkg;

   // CSR view of a bus word
   typedef struct packed {
      logic       trdy;
      logic       tie;
      logic [5:0] rsvdHi;
      logic       rrdy;
      logic       rie;
      logic       mse;
      logic       clr;
      logic [3:0] rsvdLo;
   } dzCsr_t;

   // RBUF view, also the silo entry format
   typedef struct packed {
      logic       valid;
      logic       overrun;
      logic [3:0] rsvd;
      logic [1:0] line;
      logic [7:0] char;
   } dzRbuf_t;

   // TDR view
   typedef struct packed {
      logic [5:0] rsvd;
      logic [1:0] line;
      logic [7:0] char;
   } dzTdr_t;

   // One write word, meaning picked by address
   typedef union packed {
      dzCsr_t csr;
      dzTdr_t tdr;
   } dzWord_u;

   // Request machine states
   localparam logic [2:0] stIdle = 3'd0;
   localparam logic [2:0] stAct  = 3'd1;
   localparam logic [2:0] stWait = 3'd2;
   localparam logic [2:0] stDone = 3'd3;

   // Arbiter states
   localparam logic [2:0] arbIdle     = 3'd0;
   localparam logic [2:0] arbIack     = 3'd1;
   localparam logic [2:0] arbVectRead = 3'd2;
   localparam logic [2:0] arbVectClr  = 3'd3;
   localparam logic [2:0] arbRxDone   = 3'd4;
   localparam logic [2:0] arbTxDone   = 3'd5;

endpackage

`default_nettype wire

/* hw/dzRegs.sv */
//////////////////////////////
// APB register file: CSR, RBUF and TDR decode
// Holds the enables and makes the master clear pulse
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dzMux_defines.svh"

module dzRegs
   import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // APB slave
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [15:0] pwdata,
   output logic [15:0] prdata,
   output logic        pready,
   output logic        pslverr,
   // Silo side
   input  dzRbuf_t     head,
   input  logic        notEmpty,
   output logic        pop,
   // Timer side
   input  logic        busy,
   output logic        load,
   output logic [1:0]  txLineIn,
   output logic [7:0]  txCharIn,
   // Control and status to the other blocks
   output logic        clrPulse,
   output logic        rie,
   output logic        tie,
   output logic        mse,
   output logic        rrdy,
   output logic        trdy,
   output logic        rbufRead,
   output logic        tdrWrite
);

   logic    access;
   logic    isCsr;
   logic    isRbuf;
   logic    isTdr;
   logic    csrWr;
   dzWord_u wr;
   dzCsr_t  csrRd;

   //////////////////////////////
   // Access decode
   //////////////////////////////

   // Second cycle of a transfer, zero wait states
   assign access = psel & penable;
   assign pready = 1'b1;

   assign isCsr  = (paddr == 4'(`DZ_ADDR_CSR));
   assign isRbuf = (paddr == 4'(`DZ_ADDR_RBUF));
   assign isTdr  = (paddr == 4'(`DZ_ADDR_TDR));

   assign wr = pwdata;

   assign csrWr    = access & pwrite & isCsr;
   assign rbufRead = access & ~pwrite & isRbuf;
   assign tdrWrite = access & pwrite & isTdr;

   // Silo guards itself against a pop while empty
   assign pop = rbufRead;

   // Only an idle timer accepts a character
   assign load     = tdrWrite & ~busy;
   assign txLineIn = wr.tdr.line;
   assign txCharIn = wr.tdr.char;

   // Unknown address or a TDR write that gets dropped
   assign pslverr = access & (~(isCsr | isRbuf | isTdr) | (tdrWrite & busy));

   //////////////////////////////
   // CSR bits
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rie <= 1'b0;
         tie <= 1'b0;
         mse <= 1'b0;
      end
      else if (csrWr)
      begin
         // Master clear also drops the enables
         rie <= wr.csr.rie & ~wr.csr.clr;
         tie <= wr.csr.tie & ~wr.csr.clr;
         mse <= wr.csr.mse & ~wr.csr.clr;
      end
   end

   // Clear is held through reset, then one cycle per CLR write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         clrPulse <= 1'b1;
      else
         clrPulse <= csrWr & wr.csr.clr;
   end

   // Status is live only while the scanner is enabled
   assign rrdy = mse & notEmpty;
   assign trdy = mse & ~busy;

   //////////////////////////////
   // Read data
   //////////////////////////////

   always_comb
   begin
      csrRd      = '0;
      csrRd.rrdy = rrdy;
      csrRd.rie  = rie;
      csrRd.mse  = mse;
      csrRd.trdy = trdy;
      csrRd.tie  = tie;
   end

   always_comb
   begin
      prdata = '0;
      if (isCsr)
         prdata = csrRd;
      else if (isRbuf)
         prdata = head;
   end

endmodule

`default_nettype wire

/* hw/dzRxSilo.sv */
//////////////////////////////
// Receive silo, circular FIFO with sticky overrun
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dzMux_defines.svh"

module dzRxSilo
   import dzPkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clr,
   input  logic                         push,
   input  logic [$clog2(`DZ_LINES)-1:0] line,
   input  logic [7:0]                   char,
   input  logic                         pop,
   output dzRbuf_t                      head,
   output logic                         notEmpty
);

   localparam int PtrW = $clog2(`DZ_SILO_DEPTH);
   localparam int CntW = $clog2(`DZ_SILO_DEPTH + 1);

   dzRbuf_t         mem [`DZ_SILO_DEPTH];
   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [CntW-1:0] count;
   logic            ovr;
   logic            full;
   logic            doPush;
   logic            doPop;

   assign full     = (count == CntW'(`DZ_SILO_DEPTH));
   assign notEmpty = (count != '0);
   // A full silo drops the new character
   assign doPush   = push & ~full;
   assign doPop    = pop & notEmpty;

   // Storage, no reset
   always_ff @(posedge clk)
   begin
      if (doPush)
      begin
         mem[wrPtr]         <= '0;
         mem[wrPtr].valid   <= 1'b1;
         mem[wrPtr].line    <= line;
         mem[wrPtr].char    <= char;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         ovr   <= 1'b0;
      end
      else if (clr)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         ovr   <= 1'b0;
      end
      else
      begin
         if (doPush)
            wrPtr <= (wrPtr == PtrW'(`DZ_SILO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PtrW'(`DZ_SILO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         if (doPush & ~doPop)
            count <= count + 1'b1;
         else if (doPop & ~doPush)
            count <= count - 1'b1;
         // Lost character flags the next entry read out
         ovr <= (ovr & ~doPop) | (push & full);
      end
   end

   // Empty silo reads as all zero
   always_comb
   begin
      head = '0;
      if (notEmpty)
      begin
         head         = mem[rdPtr];
         head.overrun = ovr;
      end
   end

   assert property (@(posedge clk) disable iff (rst) count <= CntW'(`DZ_SILO_DEPTH))
      else $error("silo count above depth");

   assert property (@(posedge clk) disable iff (rst)
                    (pop && !notEmpty && !push && !clr) |=> (count == '0))
      else $error("pop on empty silo moved the count");

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/dzPkg.sv
hw/dzRegs.sv
hw/dzRxSilo.sv
hw/dzCharTimer.sv
hw/dzIntr.sv
hw/dzMux.sv
tb/dzMuxTb.sv

/* tb/dzMuxTb.sv */
//////////////////////////////
// Testbench for the serial multiplexer
// Random traffic checked against a queue and timing model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dzMux_defines.svh"

module dzMuxTb
   import dzPkg::*;
();

   localparam int ClkPeriod = 8;
   localparam int NumOps    = 120;
   // Pulse seen at the negedge after the edge that raises it
   localparam int TxDelay   = `DZ_CHAR_CYCLES * ClkPeriod + ClkPeriod / 2;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [15:0] pwdata;
   logic [15:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        rxValid;
   logic [1:0]  rxLine;
   logic [7:0]  rxChar;
   logic        txValid;
   logic [1:0]  txLine;
   logic [7:0]  txChar;
   logic        iack;
   logic        vectRead;
   logic        rxIntr;
   logic        txIntr;
   logic        rxVector;

   // Model state
   dzRbuf_t     rxModel[$];
   logic        modelOvr;
   logic        modelRie;
   logic        modelTie;
   logic        modelMse;
   logic [31:0] rngState;
   time         tAccess;
   time         txTime;
   int          txCount = 0;
   logic [1:0]  txSeenLine;
   logic [7:0]  txSeenChar;
   int          errors = 0;
   int          checks = 0;
   int          testsRun = 0;
   int          testsBad = 0;

   dzMux i_dut (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .rxValid(rxValid), .rxLine(rxLine), .rxChar(rxChar),
      .txValid(txValid), .txLine(txLine), .txChar(txChar), .iack(iack),
      .vectRead(vectRead), .rxIntr(rxIntr), .txIntr(txIntr), .rxVector(rxVector)
   );

   initial
   begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // Transmit output capture
   always @(negedge clk)
   begin
      if (txValid)
      begin
         txCount++;
         txTime     = $time;
         txSeenLine = txLine;
         txSeenChar = txChar;
      end
   end

   initial
   begin
      repeat (NumOps * (`DZ_CHAR_CYCLES + 10)) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish",
               NumOps * (`DZ_CHAR_CYCLES + 10));
      $display("TEST RESULT: FAIL");
      $finish;
   end

   //////////////////////////////
   // Random numbers and checks
   //////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   task automatic reportFail(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic checkWord(input string name, input dzWord_u got, input dzWord_u exp);
      checks++;
      if (got !== exp)
         reportFail($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic checkRbuf(input string name, input dzRbuf_t got, input dzRbuf_t exp);
      checks++;
      if (got !== exp)
         reportFail($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
         reportFail($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic endTest(input string name, input int errStart);
      testsRun++;
      if (errors == errStart)
         $display("test %s: passed", name);
      else
      begin
         testsBad++;
         $display("test %s: %0d errors", name, errors - errStart);
      end
   endtask

   //////////////////////////////
   // Bus and line drivers
   //////////////////////////////

   // Setup then access cycle, sampled mid access cycle
   task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [15:0] data,
                          output logic [15:0] rdata, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      // Zero wait states
      checkBit("pready", pready, 1'b1);
      @(posedge clk);
      tAccess = $time;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic writeCsr(input logic enRie, input logic enTie, input logic enMse,
                           input logic doClr);
      dzWord_u     w;
      logic [15:0] rd;
      logic        e;
      w         = '0;
      w.csr.rie = enRie;
      w.csr.tie = enTie;
      w.csr.mse = enMse;
      w.csr.clr = doClr;
      apbXfer(1'b1, 4'(`DZ_ADDR_CSR), w, rd, e);
      checkBit("pslverr", e, 1'b0);
      // Clear drops the enables and empties the silo
      modelRie = enRie & ~doClr;
      modelTie = enTie & ~doClr;
      modelMse = enMse & ~doClr;
      if (doClr)
      begin
         rxModel.delete();
         modelOvr = 1'b0;
      end
   endtask

   task automatic readCsr(input logic timerIdle);
      dzWord_u     exp;
      logic [15:0] rd;
      logic        e;
      exp          = '0;
      exp.csr.rie  = modelRie;
      exp.csr.tie  = modelTie;
      exp.csr.mse  = modelMse;
      exp.csr.rrdy = modelMse & (rxModel.size() != 0);
      exp.csr.trdy = modelMse & timerIdle;
      apbXfer(1'b0, 4'(`DZ_ADDR_CSR), '0, rd, e);
      checkWord("prdata CSR", rd, exp);
      checkBit("pslverr", e, 1'b0);
   endtask

   task automatic readRbuf();
      dzRbuf_t     exp;
      logic [15:0] rd;
      logic        e;
      exp = '0;
      // Overrun rides on the first entry read after the loss
      if (rxModel.size() != 0)
      begin
         exp         = rxModel.pop_front();
         exp.overrun = modelOvr;
         modelOvr    = 1'b0;
      end
      apbXfer(1'b0, 4'(`DZ_ADDR_RBUF), '0, rd, e);
      checkRbuf("prdata RBUF", rd, exp);
   endtask

   task automatic sendChar(input int gap);
      logic [31:0] r;
      dzRbuf_t     ent;
      r         = nextRandom();
      ent       = '0;
      ent.valid = 1'b1;
      ent.line  = r[9:8];
      ent.char  = r[7:0];
      @(posedge clk);
      rxValid <= 1'b1;
      rxLine  <= r[9:8];
      rxChar  <= r[7:0];
      @(posedge clk);
      rxValid <= 1'b0;
      if (modelMse)
      begin
         if (rxModel.size() < `DZ_SILO_DEPTH)
            rxModel.push_back(ent);
         else
            modelOvr = 1'b1;
      end
      repeat (gap) @(posedge clk);
   endtask

   task automatic raiseRx();
      sendChar(0);
      @(posedge clk);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b1);
   endtask

   task automatic intAck();
      @(posedge clk);
      iack <= 1'b1;
      repeat (2) @(posedge clk);
      iack <= 1'b0;
      @(negedge clk);
   endtask

   // Vector read, its negation, then the one-cycle clear
   task automatic vectCycle();
      @(posedge clk);
      vectRead <= 1'b1;
      repeat (2) @(posedge clk);
      vectRead <= 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
   endtask

   // Receive wins only if it is up before iack
   task automatic priorityCase(input logic rxEarly);
      writeCsr(1'b0, 1'b0, 1'b0, 1'b1);
      writeCsr(1'b1, 1'b1, 1'b1, 1'b0);
      repeat (2) @(negedge clk);
      checkBit("txIntr", txIntr, 1'b1);
      checkBit("rxIntr", rxIntr, 1'b0);
      if (rxEarly)
         raiseRx();
      intAck();
      checkBit("rxVector", rxVector, rxEarly);
      if (!rxEarly)
         raiseRx();
      vectCycle();
      checkBit("rxVector", rxVector, rxEarly);
      checkBit("rxIntr", rxIntr, !rxEarly);
      checkBit("txIntr", txIntr, rxEarly);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      int          errStart;
      int          k;
      int          n;
      int          startCount;
      logic [31:0] r;
      logic [15:0] rd;
      logic        e;
      dzWord_u     w;
      dzWord_u     got;
      time         txStart;

      rst      <= 1'b1;
      psel     <= 1'b0;
      penable  <= 1'b0;
      pwrite   <= 1'b0;
      paddr    <= '0;
      pwdata   <= '0;
      rxValid  <= 1'b0;
      rxLine   <= '0;
      rxChar   <= '0;
      iack     <= 1'b0;
      vectRead <= 1'b0;
      rngState = 32'd79;
      modelOvr = 1'b0;
      modelRie = 1'b0;
      modelTie = 1'b0;
      modelMse = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // CSR read back with random clears and a bad address
      errStart = errors;
      for (int i = 0; i < 4; i++)
      begin
         r = nextRandom();
         writeCsr(r[0], r[1], r[2], r[3]);
         readCsr(1'b1);
      end
      apbXfer(1'b0, 4'd12, '0, rd, e);
      checkBit("pslverr", e, 1'b1);
      checkWord("prdata bad address", rd, '0);
      apbXfer(1'b1, 4'd12, 16'hffff, rd, e);
      checkBit("pslverr", e, 1'b1);
      endTest("csr", errStart);

      // Random receive bursts, drained in order
      errStart = errors;
      writeCsr(1'b0, 1'b0, 1'b0, 1'b1);
      writeCsr(1'b0, 1'b0, 1'b1, 1'b0);
      for (int round = 0; round < 3; round++)
      begin
         r = nextRandom();
         k = 1 + int'(r[2:0]);
         for (int i = 0; i < k; i++)
            sendChar(int'(r[5:4]));
         readCsr(1'b1);
         for (int i = 0; i <= k; i++)
            readRbuf();
      end
      endTest("receive", errStart);

      // Ninth character is lost and flagged
      errStart = errors;
      for (int i = 0; i < `DZ_SILO_DEPTH + 1; i++)
         sendChar(1);
      for (int i = 0; i < `DZ_SILO_DEPTH + 2; i++)
         readRbuf();
      endTest("overrun", errStart);

      // One character per character time
      errStart = errors;
      writeCsr(1'b0, 1'b0, 1'b0, 1'b1);
      writeCsr(1'b0, 1'b0, 1'b1, 1'b0);
      for (int i = 0; i < 2; i++)
      begin
         r          = nextRandom();
         w          = '0;
         w.tdr.line = r[9:8];
         w.tdr.char = r[7:0];
         startCount = txCount;
         apbXfer(1'b1, 4'(`DZ_ADDR_TDR), w, rd, e);
         txStart = tAccess;
         checkBit("pslverr", e, 1'b0);
         readCsr(1'b0);
         // Dropped while the timer is busy
         apbXfer(1'b1, 4'(`DZ_ADDR_TDR), r[31:16], rd, e);
         checkBit("pslverr on busy TDR write", e, 1'b1);
         n = 0;
         while (txCount == startCount && n < 2 * `DZ_CHAR_CYCLES)
         begin
            @(posedge clk);
            n++;
         end
         if (txCount == startCount)
            reportFail("txValid never pulsed after the TDR write");
         else
         begin
            if (int'(txTime - txStart) != TxDelay)
               reportFail($sformatf("error at %0t: txValid delay got %0d expected %0d",
                                    $time, int'(txTime - txStart), TxDelay));
            got          = '0;
            got.tdr.line = txSeenLine;
            got.tdr.char = txSeenChar;
            checkWord("txLine and txChar", got, w);
         end
         repeat (`DZ_CHAR_CYCLES + 4) @(posedge clk);
         if (txCount != startCount + 1)
            reportFail("the dropped TDR write still produced a txValid pulse");
         readCsr(1'b1);
      end
      endTest("transmit", errStart);

      errStart = errors;
      priorityCase(1'b1);
      priorityCase(1'b0);
      endTest("priority", errStart);

      // Clear with characters queued, a transmit pending and both requests up
      errStart = errors;
      sendChar(1);
      sendChar(2);
      r = nextRandom();
      // First character goes out so the transmit request comes back up
      apbXfer(1'b1, 4'(`DZ_ADDR_TDR), r[31:16] & 16'h03ff, rd, e);
      checkBit("pslverr", e, 1'b0);
      repeat (`DZ_CHAR_CYCLES + 4) @(posedge clk);
      startCount = txCount;
      apbXfer(1'b1, 4'(`DZ_ADDR_TDR), r[15:0] & 16'h03ff, rd, e);
      checkBit("pslverr", e, 1'b0);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b1);
      checkBit("txIntr", txIntr, 1'b1);
      writeCsr(1'b0, 1'b0, 1'b0, 1'b1);
      repeat (`DZ_CHAR_CYCLES + 4) @(posedge clk);
      if (txCount != startCount)
         reportFail("txValid pulsed after the clear");
      readCsr(1'b1);
      // Enables back on with the scanner off so only held state could raise a request
      writeCsr(1'b1, 1'b1, 1'b0, 1'b0);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b0);
      checkBit("txIntr", txIntr, 1'b0);
      readRbuf();
      endTest("clear", errStart);

      $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
               testsRun, testsBad, checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
